// File: bench/opn_golden.txt
# W <addr hex> <data hex> : bus write | N <cycles decimal> : idle wait
# R <test name> <expected dout hex> <expected irq_n> : status check
R reset_state 00 1
# Timer A high bits, 1000 >> 2
W 0 24
W 1 fa
R busy_set 80 1
N 36
R busy_clear 00 1
W 0 25
W 1 00
# Load and enable timer A, overflow every 24 ticks
W 0 27
W 1 05
N 3168
R ta_before 00 1
N 576
R ta_overflow 01 0
# Clear flag A with the load bit low
W 0 27
W 1 10
N 36
R ta_cleared 00 1
N 4320
R ta_stays_clear 00 1
# Timer B at 252 runs without its enable
W 0 26
W 1 fc
W 0 27
W 1 02
N 10080
R tb_masked 00 1
W 0 27
W 1 0a
N 10080
R tb_overflow 02 0

// File: filelist.f
+incdir+logic
logic/opn_pkg.sv
logic/opn_timer_if.sv
logic/opn_mmr.sv
logic/opn_timers.sv
logic/opn_top.sv
bench/opn_tb.sv

// File: Makefile
# Verilator build and run for the OPN timer block

VERILATOR   ?= verilator
FILELIST    ?= filelist.f
TB_TOP      ?= opn_tb
RTL_TOP     ?= opn_top
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
JOBS        ?= 0
VFLAGS      ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS  ?= --lint-only -Wall

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/opn_defines.svh

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/opn_tb.sv
// ########################################
// OPN timer block testbench
// Replays bus writes, waits and status
// checks from the golden file
// ########################################
`timescale 1ns/1ns
`default_nettype none

module opn_tb;

    localparam string GOLDEN_FILE = "bench/opn_golden.txt";

    logic       clk;
    logic       rst;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;

    // Parsed golden commands
    byte   cmd_q[$];
    int    arg1_q[$];
    int    arg2_q[$];
    string name_q[$];

    int tests       = 0;
    int passes      = 0;
    int fails       = 0;
    int errors      = 0;            // File and parse problems
    int cycle_cnt   = 0;
    int cycle_limit = 0;            // Zero until the golden file is read

    opn_top dut_i (
        .clk   ( clk   ),
        .rst   ( rst   ),
        .cen   ( cen   ),
        .din   ( din   ),
        .addr  ( addr  ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the golden sequence did not finish", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    // One cycle strobe, released on the edge that takes it
    task automatic bus_write(input int a, input int d);
        @(posedge clk);
        addr <= 2'(a);
        din  <= 8'(d);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic check_status(input string name, input int exp_dout, input int exp_irq);
        logic ok;
        @(negedge clk);             // Outputs settled mid cycle
        ok = 1'b1;
        tests++;
        assert (dout === 8'(exp_dout)) else begin
            $display("FAIL %s dout expected %02h actual %02h", name, 8'(exp_dout), dout);
            ok = 1'b0;
        end
        assert (irq_n === 1'(exp_irq)) else begin
            $display("FAIL %s irq_n expected %b actual %b", name, 1'(exp_irq), irq_n);
            ok = 1'b0;
        end
        if (ok) begin
            passes++;
            $display("PASS %s dout %02h irq_n %b", name, dout, irq_n);
        end else begin
            fails++;
        end
    endtask

    // Reads every command and works out the cycle budget
    task automatic load_golden(input int fd);
        string line;
        string nm;
        byte   code;
        int    rc;
        int    a1;
        int    a2;
        int    line_no;
        int    total;
        line_no = 0;
        total   = 2;                // Reset cycles
        while (!$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            line_no++;
            code = (line.len() > 0) ? line.getc(0) : 8'h0a;
            a1   = 0;
            a2   = 0;
            nm   = "";
            case (code)
                "W": rc = $sscanf(line, "W %h %h", a1, a2);
                "N": rc = $sscanf(line, "N %d", a1);
                "R": rc = $sscanf(line, "R %s %h %h", nm, a1, a2);
                default: rc = -1;
            endcase
            if (rc == -1) begin
                if (code != "#" && code != 8'h0a && code != 8'h0d && code != 8'h00) begin
                    $display("Golden file line %0d has an unknown command", line_no);
                    errors++;
                end
            end else if ((code == "N" && rc != 1) || (code != "N" && rc != code_args(code))) begin
                $display("Golden file line %0d is missing arguments", line_no);
                errors++;
            end else begin
                cmd_q.push_back(code);
                arg1_q.push_back(a1);
                arg2_q.push_back(a2);
                name_q.push_back(nm);
                total += (code == "N") ? a1 : (code == "W") ? 2 : 1;
            end
        end
        cycle_limit = total + total / 5;
    endtask

    function automatic int code_args(input byte code);
        return (code == "R") ? 3 : 2;
    endfunction

    initial begin
        int fd;
        rst  = 1'b1;
        cen  = 1'b1;                // Chip enable held high throughout
        din  = '0;
        addr = '0;
        cs_n = 1'b1;
        wr_n = 1'b1;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_FILE);
            errors++;
        end else begin
            load_golden(fd);
            $fclose(fd);
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            foreach (cmd_q[k]) begin
                case (cmd_q[k])
                    "W":     bus_write(arg1_q[k], arg2_q[k]);
                    "N":     idle_cycles(arg1_q[k]);
                    default: check_status(name_q[k], arg1_q[k], arg2_q[k]);
                endcase
            end
            if (tests == 0) begin
                $display("The golden file holds no status checks");
                errors++;
            end
        end
        $display("Tests: %0d run, %0d passed, %0d failed, %0d other errors",
                 tests, passes, fails, errors);
        if (fails == 0 && errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/opn_top.sv
// ########################################
// OPN timer and status block, top level
// CPU bus register block and two timers
// ########################################
`timescale 1ns/1ns
`default_nettype none

module opn_top (
    input  logic               clk,       // CPU clock
    input  logic               rst,
    input  logic               cen,
    input  opn_pkg::bus_byte_t din,
    input  logic [1:0]         addr,      // Bit 0 data, bit 1 bank
    input  logic               cs_n,
    input  logic               wr_n,
    output opn_pkg::bus_byte_t dout,      // Status byte
    output logic               irq_n
);

    timer_ctrl_if tmr_if ();

    // Register map and status
    opn_mmr mmr_i (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .cen    ( cen    ),
        .din    ( din    ),
        .addr   ( addr   ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .dout   ( dout   ),
        .tmr    ( tmr_if )
    );

    // Timers run from their own sample tick
    opn_timers timers_i (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .cen    ( cen    ),
        .tmr    ( tmr_if ),
        .irq_n  ( irq_n  )
    );

endmodule

`default_nettype wire

// File: logic/opn_timers.sv
// ########################################
// OPN timers A and B
// Sample tick divider, counters, overflow
// flags and interrupt line
// ########################################
`timescale 1ns/1ns
`default_nettype none

`include "opn_defines.svh"

module opn_timers (
    input  logic         clk,
    input  logic         rst,
    input  logic         cen,
    timer_ctrl_if.timers tmr,
    output logic         irq_n
);
    import opn_pkg::*;

    localparam int PRE_W = $clog2(`OPN_TB_PRE);

    tick_cnt_t        tick_cnt;
    logic             tick_wrap;
    logic             tick;           // One clk per sample
    timer_a_t         cnt_a;
    timer_b_t         cnt_b;
    logic [PRE_W-1:0] pre_b;          // Divide by 16 ahead of timer B
    logic             pre_b_wrap;
    logic             ovf_a;
    logic             ovf_b;
    logic             flag_a_nxt;
    logic             flag_b_nxt;

    // Sample tick from cen
    assign tick_wrap = tick_cnt == tick_cnt_t'(`OPN_TICK_DIV - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= cen && tick_wrap;
            if (cen) begin
                tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
            end
        end
    end

    // Timer A
    assign ovf_a = tick && tmr.load_a && (cnt_a == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= '0;
        end else if (!tmr.load_a) begin
            cnt_a <= tmr.value_a;     // Preset while stopped
        end else if (tick) begin
            cnt_a <= ovf_a ? tmr.value_a : cnt_a + 1'b1;
        end
    end

    // Timer B, steps once every 16 ticks
    assign pre_b_wrap = pre_b == PRE_W'(`OPN_TB_PRE - 1);
    assign ovf_b      = tick && tmr.load_b && pre_b_wrap && (cnt_b == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_b <= '0;
            cnt_b <= '0;
        end else if (!tmr.load_b) begin
            pre_b <= '0;
            cnt_b <= tmr.value_b;
        end else if (tick) begin
            pre_b <= pre_b_wrap ? '0 : pre_b + 1'b1;
            if (pre_b_wrap) begin
                cnt_b <= ovf_b ? tmr.value_b : cnt_b + 1'b1;
            end
        end
    end

    // Clear wins over a same-cycle overflow
    assign flag_a_nxt = tmr.clr_a ? 1'b0 : (tmr.flag_a || (ovf_a && tmr.irq_en_a));
    assign flag_b_nxt = tmr.clr_b ? 1'b0 : (tmr.flag_b || (ovf_b && tmr.irq_en_b));

    always_ff @(posedge clk) begin
        if (rst) begin
            tmr.flag_a <= 1'b0;
            tmr.flag_b <= 1'b0;
            irq_n      <= 1'b1;
        end else begin
            tmr.flag_a <= flag_a_nxt;
            tmr.flag_b <= flag_b_nxt;
            irq_n      <= !(flag_a_nxt || flag_b_nxt);    // Active low
        end
    end

    a_irq_match: assert property (
        @(posedge clk) disable iff (rst)
        irq_n == !(tmr.flag_a || tmr.flag_b)
    ) else $error("irq_n does not match the timer flags");

    // Enable comes from the register block one write earlier
    a_flag_a_en: assert property (
        @(posedge clk) disable iff (rst)
        $rose(tmr.flag_a) |-> $past(tmr.irq_en_a)
    ) else $error("flag A set with its enable low");

    a_flag_b_en: assert property (
        @(posedge clk) disable iff (rst)
        $rose(tmr.flag_b) |-> $past(tmr.irq_en_b)
    ) else $error("flag B set with its enable low");

endmodule

`default_nettype wire

// File: logic/opn_mmr.sv
// ########################################
// OPN register block
// Address latch, timer register decode,
// busy counter and status byte
// ########################################
`timescale 1ns/1ns
`default_nettype none

`include "opn_defines.svh"

module opn_mmr (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  opn_pkg::bus_byte_t din,
    input  logic [1:0]         addr,
    input  logic               cs_n,
    input  logic               wr_n,
    output opn_pkg::bus_byte_t dout,
    timer_ctrl_if.mmr          tmr
);
    import opn_pkg::*;

    reg_num_t  reg_num;
    logic      bank;            // addr[1] of the last address write
    busy_cnt_t busy_cnt;
    logic      busy;
    logic      write;
    logic      addr_wr;
    logic      data_wr;
    logic      tmr_wr;

    assign write   = cen && !cs_n && !wr_n;
    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];
    assign tmr_wr  = data_wr && !bank;    // Timers live in bank 0

    // Register number latch
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_num <= '0;
            bank    <= 1'b0;
        end else if (addr_wr) begin
            reg_num <= din;
            bank    <= addr[1];
        end
    end

    // Timer reload values
    always_ff @(posedge clk) begin
        if (tmr_wr) begin
            case (reg_num)
                `OPN_REG_TA_HI: tmr.value_a[`OPN_TA_W-1:2] <= din;
                `OPN_REG_TA_LO: tmr.value_a[1:0]           <= din[1:0];
                `OPN_REG_TB:    tmr.value_b                <= din;
                default: ;
            endcase
        end
    end

    // Register 0x27
    always_ff @(posedge clk) begin
        if (rst) begin
            tmr.load_a   <= 1'b0;
            tmr.load_b   <= 1'b0;
            tmr.irq_en_a <= 1'b0;
            tmr.irq_en_b <= 1'b0;
            tmr.clr_a    <= 1'b0;
            tmr.clr_b    <= 1'b0;
        end else begin
            tmr.clr_a <= 1'b0;
            tmr.clr_b <= 1'b0;
            if (tmr_wr && reg_num == `OPN_REG_TCTL) begin
                tmr.load_a   <= din[`OPN_TCTL_LOAD_A];
                tmr.load_b   <= din[`OPN_TCTL_LOAD_B];
                tmr.irq_en_a <= din[`OPN_TCTL_EN_A];
                tmr.irq_en_b <= din[`OPN_TCTL_EN_B];
                tmr.clr_a    <= din[`OPN_TCTL_CLR_A];   // Flag reset, not stored
                tmr.clr_b    <= din[`OPN_TCTL_CLR_B];
            end
        end
    end

    // Busy follows every data write, any bank
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= busy_cnt_t'(`OPN_BUSY_LEN);     // Restart on each write
        end else if (cen && busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = busy_cnt != '0;

    // Status byte, always on the bus
    always_comb begin
        dout = '0;
        dout[`OPN_STATUS_BUSY]   = busy;
        dout[`OPN_STATUS_FLAG_B] = tmr.flag_b;
        dout[`OPN_STATUS_FLAG_A] = tmr.flag_a;
    end

    // Counter only reloads to the top value and counts down
    a_busy_range: assert property (
        @(posedge clk) disable iff (rst)
        busy_cnt <= busy_cnt_t'(`OPN_BUSY_LEN)
    ) else $error("busy counter above OPN_BUSY_LEN");

    a_clr_a_pulse: assert property (
        @(posedge clk) disable iff (rst)
        tmr.clr_a |=> !tmr.clr_a
    ) else $error("clr_a held for two cycles");

endmodule

`default_nettype wire

// File: logic/opn_timer_if.sv
// ########################################
// OPN timer control interface
// Register block settings and timer flags
// ########################################
`timescale 1ns/1ns
`default_nettype none

interface timer_ctrl_if;
    import opn_pkg::*;

    timer_a_t value_a;
    timer_b_t value_b;
    logic     load_a;       // Counter runs while set
    logic     load_b;
    logic     irq_en_a;
    logic     irq_en_b;
    logic     clr_a;        // One cycle pulses
    logic     clr_b;
    logic     flag_a;
    logic     flag_b;

    modport mmr (
        output value_a, value_b, load_a, load_b,
        output irq_en_a, irq_en_b, clr_a, clr_b,
        input  flag_a, flag_b
    );

    modport timers (
        input  value_a, value_b, load_a, load_b,
        input  irq_en_a, irq_en_b, clr_a, clr_b,
        output flag_a, flag_b
    );

endinterface

`default_nettype wire

// File: logic/opn_pkg.sv
// ########################################
// OPN timer block types
// Vector types for the CPU bus and timers
// ########################################
`default_nettype none

`include "opn_defines.svh"

package opn_pkg;

    typedef logic [7:0] bus_byte_t;              // CPU data bus
    typedef logic [7:0] reg_num_t;               // Latched register number

    // Reload values and running counts
    typedef logic [`OPN_TA_W-1:0] timer_a_t;
    typedef logic [`OPN_TB_W-1:0] timer_b_t;

    typedef logic [7:0] tick_cnt_t;              // Up to OPN_TICK_DIV-1
    typedef logic [5:0] busy_cnt_t;              // Up to OPN_BUSY_LEN

endpackage

`default_nettype wire

// File: logic/opn_defines.svh
// ########################################
// OPN timer block definitions
// Register map, control bits, timing constants
// ########################################
`ifndef OPN_DEFINES_SVH
`define OPN_DEFINES_SVH

// Timer registers, bank 0 only
`define OPN_REG_TA_HI     8'h24   // Timer A bits 9..2
`define OPN_REG_TA_LO     8'h25   // Timer A bits 1..0
`define OPN_REG_TB        8'h26
`define OPN_REG_TCTL      8'h27   // Load, enable and flag reset

// Bit positions in register 0x27
`define OPN_TCTL_LOAD_A   0
`define OPN_TCTL_LOAD_B   1
`define OPN_TCTL_EN_A     2
`define OPN_TCTL_EN_B     3
`define OPN_TCTL_CLR_A    4
`define OPN_TCTL_CLR_B    5

`define OPN_TA_W          10
`define OPN_TB_W          8

`define OPN_TICK_DIV      144     // cen/6 prescale times 24 slots
`define OPN_TB_PRE        16
`define OPN_BUSY_LEN      32      // In cen pulses

// Status byte layout
`define OPN_STATUS_BUSY   7
`define OPN_STATUS_FLAG_B 1
`define OPN_STATUS_FLAG_A 0

`endif
